// ==== design/divPkg.sv ====
`default_nettype none

package divPkg;

    // operand and result word
    typedef logic [31:0] dataT;

    // upper half of the remainder register
    // one guard bit above the word so that the shifted partial remainder
    // and the trial difference both fit; bit 32 is the sign
    typedef logic [32:0] remUpperT;

    // number of quotient bits, one per iteration
    localparam int DIV_STEPS = 32;

    // request payload
    typedef struct packed {
        dataT dividend;
        dataT divisor;
    } divReqT;

    // response payload, 65 bits
    typedef struct packed {
        dataT quotient;
        dataT remainder;
        logic divByZero;
    } divRespT;

    // what a remainder write takes
    typedef enum logic [1:0] {
        // upper cleared, lower takes the dividend
        REM_SRC_LOAD       = 2'd0,
        // upper takes the add/subtract result
        REM_SRC_ALU        = 2'd1,
        // lowest quotient bit set
        REM_SRC_APPEND_ONE = 2'd2
    } remSrcT;

    // controller states
    // one division step walks SHIFT -> SUBTRACT -> DECIDE
    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        SHIFT    = 3'd1,
        SUBTRACT = 3'd2,
        DECIDE   = 3'd3,
        DONE     = 3'd4
    } ctrlStateT;

endpackage

`default_nettype wire

// ==== design/divControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module divControl
    import divPkg::*;
(
    input  wire    clk,
    input  wire    rst,
    input  wire    reqValid,
    output logic   reqReady,
    output logic   respValid,
    input  wire    respReady,
    input  wire    remSign,
    output logic   remWrite,
    output logic   remShift,
    output remSrcT remSrc,
    output logic   aluSubtract,
    output logic   divisorLoad
);

    ctrlStateT state;
    ctrlStateT stateNext;

    // remaining steps, loaded on acceptance
    logic [5:0] stepCount;
    logic       lastStep;

    assign lastStep = (stepCount == 6'd1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= stateNext;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stepCount <= '0;
        end else begin
            if (state == IDLE && reqValid) begin
                stepCount <= 6'(DIV_STEPS);
            end else if (state == DECIDE) begin
                stepCount <= stepCount - 6'd1;
            end
        end
    end

    // next state
    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                if (reqValid) begin
                    stateNext = SHIFT;
                end
            end
            SHIFT: begin
                stateNext = SUBTRACT;
            end
            SUBTRACT: begin
                stateNext = DECIDE;
            end
            DECIDE: begin
                if (lastStep) begin
                    stateNext = DONE;
                end else begin
                    stateNext = SHIFT;
                end
            end
            DONE: begin
                // held here as long as the consumer stalls
                if (respReady) begin
                    stateNext = IDLE;
                end
            end
            default: begin
                stateNext = IDLE;
            end
        endcase
    end

    // datapath commands and handshake outputs
    always_comb begin
        reqReady    = 1'b0;
        respValid   = 1'b0;
        remWrite    = 1'b0;
        remShift    = 1'b0;
        remSrc      = REM_SRC_LOAD;
        aluSubtract = 1'b0;
        divisorLoad = 1'b0;
        case (state)
            IDLE: begin
                reqReady = 1'b1;
                // operands are captured on the accepting edge
                remWrite    = reqValid;
                divisorLoad = reqValid;
                remSrc      = REM_SRC_LOAD;
            end
            SHIFT: begin
                remShift = 1'b1;
            end
            SUBTRACT: begin
                remWrite    = 1'b1;
                remSrc      = REM_SRC_ALU;
                aluSubtract = 1'b1;
            end
            DECIDE: begin
                remWrite = 1'b1;
                if (remSign) begin
                    // trial went negative, add divisor back
                    remSrc      = REM_SRC_ALU;
                    aluSubtract = 1'b0;
                end else begin
                    remSrc = REM_SRC_APPEND_ONE;
                end
            end
            DONE: begin
                respValid = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // a new request is only taken once the previous result has left
    assert property (@(posedge clk) disable iff (rst)
        !(reqReady && respValid))
        else $error("reqReady and respValid high together");

    assert property (@(posedge clk) disable iff (rst)
        !(remWrite && remShift))
        else $error("remainder write and shift in the same cycle");

endmodule

`default_nettype wire

// ==== design/divRemainderPath.sv ====
`timescale 1ns/1ps
`default_nettype none

module divRemainderPath
    import divPkg::*;
(
    input  wire     clk,
    input  wire     rst,
    input  divReqT  req,
    input  wire     remWrite,
    input  wire     remShift,
    input  remSrcT  remSrc,
    input  wire     aluSubtract,
    input  wire     divisorLoad,
    output logic    remSign,
    output divRespT resp
);

    dataT     divisor;
    remUpperT upper;
    dataT     lower;

    // zero-extended divisor for the 33-bit adder
    remUpperT divisorExt;
    remUpperT aluResult;

    // write-source selection results
    remUpperT upperNext;
    dataT     lowerNext;

    assign divisorExt = {1'b0, divisor};

    // single adder, subtracts for the trial and adds for the restore
    always_comb begin
        if (aluSubtract) begin
            aluResult = upper - divisorExt;
        end else begin
            aluResult = upper + divisorExt;
        end
    end

    always_comb begin
        upperNext = upper;
        lowerNext = lower;
        case (remSrc)
            REM_SRC_LOAD: begin
                upperNext = '0;
                lowerNext = req.dividend;
            end
            REM_SRC_ALU: begin
                upperNext = aluResult;
            end
            REM_SRC_APPEND_ONE: begin
                lowerNext = {lower[31:1], 1'b1};
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            divisor <= '0;
        end else if (divisorLoad) begin
            divisor <= req.divisor;
        end
    end

    // whole 65-bit register moves left on a shift, zero enters at bit 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            upper <= '0;
            lower <= '0;
        end else if (remShift) begin
            upper <= {upper[31:0], lower[31]};
            lower <= {lower[30:0], 1'b0};
        end else if (remWrite) begin
            upper <= upperNext;
            lower <= lowerNext;
        end
    end

    assign remSign = upper[32];

    // result fields come straight from the registers
    assign resp.quotient  = lower;
    assign resp.remainder = upper[31:0];
    assign resp.divByZero = (divisor == '0);

    // restore or append always leaves a non-negative partial remainder
    assert property (@(posedge clk) disable iff (rst)
        (remWrite && (remSrc == REM_SRC_APPEND_ONE ||
                      (remSrc == REM_SRC_ALU && !aluSubtract)))
        |=> !remSign)
        else $error("partial remainder negative after decide step");

endmodule

`default_nettype wire

// ==== design/divUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module divUnit
    import divPkg::*;
(
    input  wire     clk,
    input  wire     rst,
    input  wire     reqValid,
    output logic    reqReady,
    input  divReqT  req,
    output logic    respValid,
    input  wire     respReady,
    output divRespT resp
);

    // controller to datapath commands
    logic   remWrite;
    logic   remShift;
    remSrcT remSrc;
    logic   aluSubtract;
    logic   divisorLoad;

    // datapath status back to the controller
    logic   remSign;

    divControl ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .reqValid    (reqValid),
        .reqReady    (reqReady),
        .respValid   (respValid),
        .respReady   (respReady),
        .remSign     (remSign),
        .remWrite    (remWrite),
        .remShift    (remShift),
        .remSrc      (remSrc),
        .aluSubtract (aluSubtract),
        .divisorLoad (divisorLoad)
    );

    // operands enter here, results leave from its registers
    divRemainderPath path_i (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .remWrite    (remWrite),
        .remShift    (remShift),
        .remSrc      (remSrc),
        .aluSubtract (aluSubtract),
        .divisorLoad (divisorLoad),
        .remSign     (remSign),
        .resp        (resp)
    );

endmodule

`default_nettype wire

// ==== testbench/divScoreboard.sv ====
`timescale 1ns/1ps
`default_nettype none

module divScoreboard
    import divPkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         reqValid,
    input  wire         reqReady,
    input  divReqT      req,
    input  wire         respValid,
    input  wire         respReady,
    input  divRespT     resp,
    output logic        checkFailed,
    output int unsigned takenCount
);

    // raised by any failing check
    event failEvent;
    logic failFlag = 1'b0;

    // expected results, oldest first
    divRespT expQueue[$];
    divRespT expHead;
    logic    hasExpected;

    // response as sampled one edge earlier
    divRespT heldResp;

    logic        busy;
    int unsigned sinceAccept;
    logic        accepted;
    logic        taken;

    assign accepted = reqValid && reqReady;
    assign taken = respValid && respReady;
    assign checkFailed = failFlag;

    // unsigned restoring division result, zero divisor gives all ones
    function automatic divRespT referenceResult(input divReqT r);
        divRespT result;
        if (r.divisor == '0) begin
            result.quotient = '1;
            result.remainder = r.dividend;
            result.divByZero = 1'b1;
        end else begin
            result.quotient = r.dividend / r.divisor;
            result.remainder = r.dividend % r.divisor;
            result.divByZero = 1'b0;
        end
        return result;
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            expQueue.delete();
            expHead <= '0;
            hasExpected <= 1'b0;
            heldResp <= '0;
            busy <= 1'b0;
            sinceAccept <= 0;
            takenCount <= 0;
        end else begin
            heldResp <= resp;
            if (accepted) begin
                expQueue.push_back(referenceResult(req));
                busy <= 1'b1;
                sinceAccept <= 0;
            end else if (!respValid) begin
                sinceAccept <= sinceAccept + 1;
            end
            if (taken) begin
                if (expQueue.size() != 0) begin
                    void'(expQueue.pop_front());
                end
                busy <= 1'b0;
                takenCount <= takenCount + 1;
            end
            hasExpected <= (expQueue.size() != 0);
            expHead <= (expQueue.size() != 0) ? expQueue[0] : '0;
        end
    end

    always @(failEvent) begin
        failFlag = 1'b1;
    end

    // result fields on every taken response
    assert property (@(posedge clk) disable iff (rst)
        taken |-> resp.quotient == expHead.quotient)
        else begin
            $display("MISMATCH at %0t: resp.quotient got %h expected %h",
                     $time, $sampled(resp.quotient), $sampled(expHead.quotient));
            -> failEvent;
        end

    assert property (@(posedge clk) disable iff (rst)
        taken |-> resp.remainder == expHead.remainder)
        else begin
            $display("MISMATCH at %0t: resp.remainder got %h expected %h",
                     $time, $sampled(resp.remainder), $sampled(expHead.remainder));
            -> failEvent;
        end

    assert property (@(posedge clk) disable iff (rst)
        taken |-> resp.divByZero == expHead.divByZero)
        else begin
            $display("MISMATCH at %0t: resp.divByZero got %b expected %b",
                     $time, $sampled(resp.divByZero), $sampled(expHead.divByZero));
            -> failEvent;
        end

    assert property (@(posedge clk) disable iff (rst)
        taken |-> hasExpected)
        else begin
            $display("a response was taken with no request outstanding");
            -> failEvent;
        end

    // stalled response must hold
    assert property (@(posedge clk) disable iff (rst)
        respValid && !respReady |=> respValid)
        else begin
            $display("respValid dropped before the response was taken");
            -> failEvent;
        end

    assert property (@(posedge clk) disable iff (rst)
        respValid && !respReady |=> resp == heldResp)
        else begin
            $display("MISMATCH at %0t: resp got %h expected %h",
                     $time, $sampled(resp), $sampled(heldResp));
            -> failEvent;
        end

    assert property (@(posedge clk) disable iff (rst)
        busy |-> !reqReady)
        else begin
            $display("reqReady was high while a division was in progress");
            -> failEvent;
        end

    // three cycles per quotient bit
    assert property (@(posedge clk) disable iff (rst)
        $rose(respValid) |-> sinceAccept == 3 * DIV_STEPS)
        else begin
            $display("MISMATCH at %0t: latency got %0d expected %0d",
                     $time, $sampled(sinceAccept), 3 * DIV_STEPS);
            -> failEvent;
        end

    assert property (@(posedge clk)
        $fell(rst) |-> reqReady && !respValid)
        else begin
            $display("handshake outputs were wrong right after reset");
            -> failEvent;
        end

endmodule

`default_nettype wire

// ==== testbench/divTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module divTb
    import divPkg::*;
();

    localparam int NUM_DIRECTED = 10;
    localparam int NUM_RANDOM = 200;
    localparam int NUM_REQS = NUM_DIRECTED + NUM_RANDOM;
    localparam int WATCHDOG_CYCLES = NUM_REQS * 150 + 1000;

    // directed operand pairs with the zero divisors last
    localparam dataT DIR_DIVIDEND[NUM_DIRECTED] = '{
        32'd0, 32'd7, 32'd100, 32'hffff_ffff, 32'hffff_ffff,
        32'd1, 32'h8000_0000, 32'd0, 32'd12345, 32'hffff_ffff
    };
    localparam dataT DIR_DIVISOR[NUM_DIRECTED] = '{
        32'd1, 32'd7, 32'd7, 32'd1, 32'hffff_ffff,
        32'hffff_ffff, 32'd3, 32'd0, 32'd0, 32'd0
    };

    logic        clk;
    logic        rst;
    logic        reqValid;
    logic        reqReady;
    divReqT      req;
    logic        respValid;
    logic        respReady;
    divRespT     resp;
    logic        checkFailed;
    int unsigned takenCount;

    // operands and consumer stalls built before reset is released
    dataT        dividendList[NUM_REQS];
    dataT        divisorList[NUM_REQS];
    int          stallList[NUM_REQS];
    logic [31:0] lcgState;

    divUnit dut_i (
        .clk       (clk),
        .rst       (rst),
        .reqValid  (reqValid),
        .reqReady  (reqReady),
        .req       (req),
        .respValid (respValid),
        .respReady (respReady),
        .resp      (resp)
    );

    divScoreboard sb_i (
        .clk         (clk),
        .rst         (rst),
        .reqValid    (reqValid),
        .reqReady    (reqReady),
        .req         (req),
        .respValid   (respValid),
        .respReady   (respReady),
        .resp        (resp),
        .checkFailed (checkFailed),
        .takenCount  (takenCount)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic buildStimulus();
        logic [31:0] raw;
        logic [31:0] pick;
        for (int i = 0; i < NUM_DIRECTED; i++) begin
            dividendList[i] = DIR_DIVIDEND[i];
            divisorList[i] = DIR_DIVISOR[i];
            stallList[i] = 0;
        end
        for (int i = NUM_DIRECTED; i < NUM_REQS; i++) begin
            dividendList[i] = lcgNext();
            raw = lcgNext();
            pick = lcgNext();
            // mix of full words and small divisors
            case (pick[31:30])
                2'd0: divisorList[i] = raw;
                2'd1: divisorList[i] = raw & 32'h0000_00ff;
                2'd2: divisorList[i] = raw & 32'h0000_ffff;
                default: divisorList[i] = raw >> pick[20:16];
            endcase
            stallList[i] = int'((lcgNext() >> 16) % 21);
        end
    endtask

    // next request is offered as soon as the previous one is accepted
    task automatic sendRequests();
        for (int i = 0; i < NUM_REQS; i++) begin
            reqValid = 1'b1;
            req.dividend = dividendList[i];
            req.divisor = divisorList[i];
            while (!reqReady) begin
                @(negedge clk);
            end
            @(negedge clk);
        end
        reqValid = 1'b0;
    endtask

    task automatic takeResponses();
        for (int i = 0; i < NUM_REQS; i++) begin
            while (!respValid) begin
                @(negedge clk);
            end
            repeat (stallList[i]) @(negedge clk);
            respReady = 1'b1;
            @(negedge clk);
            respReady = 1'b0;
        end
    endtask

    always @(posedge checkFailed) begin
        $display("SOME TESTS FAILED");
        $fatal(1, "scoreboard check failed");
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, the divider did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst = 1'b1;
        reqValid = 1'b0;
        respReady = 1'b0;
        req = '0;
        lcgState = 32'hf9ee;
        buildStimulus();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        fork
            sendRequests();
            takeResponses();
        join
        repeat (5) @(negedge clk);
        if (takenCount == NUM_REQS) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("only %0d of %0d responses were taken", takenCount, NUM_REQS);
            $display("SOME TESTS FAILED");
            $fatal(1, "response count wrong");
        end
    end

endmodule

`default_nettype wire

// ==== flist.f ====
design/divPkg.sv
design/divControl.sv
design/divRemainderPath.sv
design/divUnit.sv
testbench/divScoreboard.sv
testbench/divTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the divider testbench with Verilator
# exit status is nonzero when the build fails or the run ends in $fatal

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module divTb \
    -f flist.f \
    -o divSim &&
./obj_dir/divSim || exit 1
